// ==== hull_pkg.sv ====
`default_nettype none

package hull_pkg;

    // ----------------------------------------------------------------------
    // widths and basic types
    // ----------------------------------------------------------------------
    localparam int coord_w    = 8;
    localparam int max_points = 32;

    typedef logic [coord_w-1:0]            coord_t;
    typedef logic [$clog2(max_points)-1:0] index_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // twice the hull area, never halved
    typedef logic [2*coord_w:0] area_t;

    typedef enum logic [2:0] {READ, SWAP, SORT, SCAN, AREA, DONE} phase_t;

    typedef enum logic [2:0] {HOLD, LOAD, SWAP_PIVOT, SORT_EVEN, SORT_ODD, PUSH} store_op_t;

    // one write into the point store
    typedef struct packed {
        logic   en;
        index_t index;
        point_t point;
    } store_write_t;

    // ----------------------------------------------------------------------
    // geometry helpers
    // ----------------------------------------------------------------------

    // cross product of (a - o) and (b - o), positive for a left turn
    function automatic logic signed [2*coord_w+1:0] cross_turn(point_t o, point_t a, point_t b);
        logic signed [coord_w:0] ax;
        logic signed [coord_w:0] ay;
        logic signed [coord_w:0] bx;
        logic signed [coord_w:0] by;
        ax = $signed({1'b0, a.x}) - $signed({1'b0, o.x});
        ay = $signed({1'b0, a.y}) - $signed({1'b0, o.y});
        bx = $signed({1'b0, b.x}) - $signed({1'b0, o.x});
        by = $signed({1'b0, b.y}) - $signed({1'b0, o.y});
        return ax * by - bx * ay;
    endfunction

    // true when a sorts after b around pivot p
    function automatic logic angle_after(point_t p, point_t a, point_t b);
        logic signed [2*coord_w+1:0] turn;
        coord_t                      da_x;
        coord_t                      db_x;
        coord_t                      da_y;
        coord_t                      db_y;
        turn = cross_turn(p, a, b);
        // pivot is lowest, so dy is never negative
        da_x = (a.x > p.x) ? a.x - p.x : p.x - a.x;
        db_x = (b.x > p.x) ? b.x - p.x : p.x - b.x;
        da_y = a.y - p.y;
        db_y = b.y - p.y;
        // on a shared ray the farther point goes last
        return (turn < 0) ||
               (turn == 0 && (da_x > db_x || (da_x == db_x && da_y > db_y)));
    endfunction

endpackage

`default_nettype wire

// ==== hull_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module hull_sequencer #(
    parameter int num_points = 20
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  scan_end,
    input  wire logic                  area_end,
    output hull_pkg::phase_t           phase,
    output hull_pkg::store_op_t        op,
    output logic                       done
);

    localparam hull_pkg::index_t last_slot = hull_pkg::index_t'(num_points - 1);

    hull_pkg::phase_t next_phase;
    hull_pkg::index_t load_cnt;
    hull_pkg::index_t sort_cnt;

    // ----------------------------------------------------------------------
    // phase transitions
    // ----------------------------------------------------------------------
    always_comb begin
        case (phase)
            hull_pkg::READ: next_phase = (load_cnt == last_slot) ? hull_pkg::SWAP : hull_pkg::READ;
            hull_pkg::SWAP: next_phase = hull_pkg::SORT;
            hull_pkg::SORT: next_phase = (sort_cnt == last_slot) ? hull_pkg::SCAN : hull_pkg::SORT;
            hull_pkg::SCAN: next_phase = scan_end ? hull_pkg::AREA : hull_pkg::SCAN;
            hull_pkg::AREA: next_phase = area_end ? hull_pkg::DONE : hull_pkg::AREA;
            default:        next_phase = hull_pkg::READ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase    <= hull_pkg::READ;
            load_cnt <= '0;
            sort_cnt <= '0;
        end else begin
            phase <= next_phase;
            // counters run only inside their own phase
            load_cnt <= (phase == hull_pkg::READ) ? load_cnt + 1'b1 : '0;
            sort_cnt <= (phase == hull_pkg::SORT) ? sort_cnt + 1'b1 : '0;
        end
    end

    // ----------------------------------------------------------------------
    // store opcode per cycle
    // ----------------------------------------------------------------------
    always_comb begin
        case (phase)
            hull_pkg::READ: op = hull_pkg::LOAD;
            hull_pkg::SWAP: op = hull_pkg::SWAP_PIVOT;
            // first pass is even, then alternate
            hull_pkg::SORT: op = sort_cnt[0] ? hull_pkg::SORT_ODD : hull_pkg::SORT_EVEN;
            hull_pkg::SCAN: op = hull_pkg::PUSH;
            default:        op = hull_pkg::HOLD;
        endcase
    end

    assign done = (phase == hull_pkg::DONE);

endmodule

`default_nettype wire

// ==== point_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module point_loader #(
    parameter int num_points = 20
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire hull_pkg::phase_t       phase,
    input  wire hull_pkg::coord_t       x,
    input  wire hull_pkg::coord_t       y,
    output hull_pkg::store_write_t      load_wr,
    output hull_pkg::index_t            pivot_index
);

    hull_pkg::index_t slot;
    hull_pkg::point_t best;
    logic             take;

    // lowest y wins, then lowest x; slot 0 always seeds the search
    assign take = (slot == '0) || (y < best.y) || (y == best.y && x < best.x);

    assign load_wr.en    = (phase == hull_pkg::READ);
    assign load_wr.index = slot;
    assign load_wr.point = '{x: x, y: y};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot        <= '0;
            pivot_index <= '0;
        end else if (load_wr.en) begin
            slot <= (slot == hull_pkg::index_t'(num_points - 1)) ? '0 : slot + 1'b1;
            if (take) begin
                pivot_index <= slot;
            end
        end else begin
            slot <= '0;
        end
    end

    // copy of the current best candidate
    always_ff @(posedge clk) begin
        if (load_wr.en && take) begin
            best <= load_wr.point;
        end
    end

endmodule

`default_nettype wire

// ==== point_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module point_store #(
    parameter int num_points = 20
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire hull_pkg::store_op_t    op,
    input  wire hull_pkg::store_write_t load_wr,
    input  wire hull_pkg::index_t       pivot_index,
    input  wire hull_pkg::store_write_t push_wr,
    input  wire hull_pkg::index_t       cur_index,
    input  wire hull_pkg::index_t       top_index,
    input  wire hull_pkg::index_t       under_index,
    output hull_pkg::point_t            cur_point,
    output hull_pkg::point_t            top_point,
    output hull_pkg::point_t            under_point
);

    hull_pkg::point_t mem [num_points];

    // after[j] set means slot j must move behind slot j+1
    logic [num_points-2:1] after;

    // ----------------------------------------------------------------------
    // compare network
    // ----------------------------------------------------------------------
    // one comparator per neighbour pair that both passes share
    always_comb begin
        after = '0;
        for (int j = 1; j < num_points - 1; j++) begin
            after[j] = hull_pkg::angle_after(mem[0], mem[j], mem[j+1]);
        end
    end

    // ----------------------------------------------------------------------
    // array update, one opcode per cycle
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_points; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (op)
                hull_pkg::LOAD: begin
                    if (load_wr.en) begin
                        mem[load_wr.index] <= load_wr.point;
                    end
                end
                hull_pkg::SWAP_PIVOT: begin
                    mem[0]           <= mem[pivot_index];
                    mem[pivot_index] <= mem[0];
                end
                hull_pkg::SORT_EVEN: begin
                    // pairs (1,2) (3,4) ...
                    for (int j = 1; j < num_points - 1; j += 2) begin
                        if (after[j]) begin
                            mem[j]   <= mem[j+1];
                            mem[j+1] <= mem[j];
                        end
                    end
                end
                hull_pkg::SORT_ODD: begin
                    // pairs (2,3) (4,5) ...
                    for (int j = 2; j < num_points - 1; j += 2) begin
                        if (after[j]) begin
                            mem[j]   <= mem[j+1];
                            mem[j+1] <= mem[j];
                        end
                    end
                end
                hull_pkg::PUSH: begin
                    if (push_wr.en) begin
                        mem[push_wr.index] <= push_wr.point;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // read ports
    // ----------------------------------------------------------------------
    // indices past the last slot read as the origin
    assign cur_point   = (cur_index < num_points)   ? mem[cur_index]   : '0;
    assign top_point   = (top_index < num_points)   ? mem[top_index]   : '0;
    assign under_point = (under_index < num_points) ? mem[under_index] : '0;

endmodule

`default_nettype wire

// ==== hull_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module hull_engine #(
    parameter int num_points = 20
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire hull_pkg::phase_t       phase,
    input  wire hull_pkg::point_t       cur_point,
    input  wire hull_pkg::point_t       top_point,
    input  wire hull_pkg::point_t       under_point,
    output hull_pkg::index_t            cur_index,
    output hull_pkg::index_t            top_index,
    output hull_pkg::index_t            under_index,
    output hull_pkg::store_write_t      push_wr,
    output logic                        scan_end,
    output logic                        area_end,
    output hull_pkg::area_t             area
);

    // counters must reach num_points itself
    localparam int cnt_w   = $bits(hull_pkg::index_t) + 1;
    localparam int cross_w = 2 * hull_pkg::coord_w + 2;
    localparam int acc_w   = $bits(hull_pkg::area_t) + 3;

    logic [cnt_w-1:0]         stack_size;
    logic [cnt_w-1:0]         cur_idx;
    logic [cnt_w-1:0]         walk;
    logic [cnt_w-1:0]         walk_next;
    logic                     walk_last;
    logic                     cur_ok;
    logic                     do_push;
    logic signed [cross_w-1:0] turn;
    logic signed [cross_w-1:0] term;
    logic signed [acc_w-1:0]   acc;
    logic signed [acc_w-1:0]   acc_next;

    // ----------------------------------------------------------------------
    // scan decision and area term
    // ----------------------------------------------------------------------
    always_comb begin
        cur_ok    = (cur_idx < num_points);
        turn      = hull_pkg::cross_turn(under_point, top_point, cur_point);
        do_push   = (phase == hull_pkg::SCAN) && cur_ok && (stack_size == 1 || turn > 0);
        walk_last = (walk == stack_size - 1'b1);
        walk_next = walk_last ? '0 : walk + 1'b1;
        // shoelace term is the cross product about the origin
        term      = hull_pkg::cross_turn('0, top_point, cur_point);
        acc_next  = acc + term;
    end

    assign top_index   = (phase == hull_pkg::AREA) ? hull_pkg::index_t'(walk)
                                                   : hull_pkg::index_t'(stack_size - 1'b1);
    assign cur_index   = (phase == hull_pkg::AREA) ? hull_pkg::index_t'(walk_next)
                                                   : hull_pkg::index_t'(cur_idx);
    assign under_index = hull_pkg::index_t'(stack_size - 2'd2);

    assign push_wr.en    = do_push;
    assign push_wr.index = hull_pkg::index_t'(stack_size);
    assign push_wr.point = cur_point;

    assign scan_end = (phase == hull_pkg::SCAN) && !cur_ok;
    assign area_end = (phase == hull_pkg::AREA) && walk_last;

    // ----------------------------------------------------------------------
    // stack and accumulator
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stack_size <= cnt_w'(2);
            cur_idx    <= cnt_w'(2);
            walk       <= '0;
            acc        <= '0;
            area       <= '0;
        end else begin
            case (phase)
                hull_pkg::SCAN: begin
                    if (do_push) begin
                        stack_size <= stack_size + 1'b1;
                        cur_idx    <= cur_idx + 1'b1;
                    end else if (cur_ok) begin
                        // pop and retry cur against the new top
                        stack_size <= stack_size - 1'b1;
                    end
                end
                hull_pkg::AREA: begin
                    if (walk_last) begin
                        area <= hull_pkg::area_t'(acc_next);
                    end else begin
                        walk <= walk_next;
                        acc  <= acc_next;
                    end
                end
                default: begin
                    // slots 0 and 1 start on the stack
                    stack_size <= cnt_w'(2);
                    cur_idx    <= cnt_w'(2);
                    walk       <= '0;
                    acc        <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== convex_hull_area.sv ====
`timescale 1ns/100ps
`default_nettype none

module convex_hull_area #(
    parameter int num_points = 20
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire hull_pkg::coord_t  x,
    input  wire hull_pkg::coord_t  y,
    output logic                   done,
    output hull_pkg::area_t        area
);

    hull_pkg::phase_t       phase;
    hull_pkg::store_op_t    op;
    hull_pkg::store_write_t load_wr;
    hull_pkg::store_write_t push_wr;
    hull_pkg::index_t       pivot_index;
    hull_pkg::index_t       cur_index;
    hull_pkg::index_t       top_index;
    hull_pkg::index_t       under_index;
    hull_pkg::point_t       cur_point;
    hull_pkg::point_t       top_point;
    hull_pkg::point_t       under_point;
    logic                   scan_end;
    logic                   area_end;

    hull_sequencer #(.num_points(num_points)) u_sequencer (
        .clk(clk), .reset(reset), .scan_end(scan_end), .area_end(area_end),
        .phase(phase), .op(op), .done(done)
    );

    point_loader #(.num_points(num_points)) u_loader (
        .clk(clk), .reset(reset), .phase(phase), .x(x), .y(y),
        .load_wr(load_wr), .pivot_index(pivot_index)
    );

    point_store #(.num_points(num_points)) u_store (
        .clk(clk), .reset(reset), .op(op), .load_wr(load_wr),
        .pivot_index(pivot_index), .push_wr(push_wr),
        .cur_index(cur_index), .top_index(top_index), .under_index(under_index),
        .cur_point(cur_point), .top_point(top_point), .under_point(under_point)
    );

    hull_engine #(.num_points(num_points)) u_engine (
        .clk(clk), .reset(reset), .phase(phase),
        .cur_point(cur_point), .top_point(top_point), .under_point(under_point),
        .cur_index(cur_index), .top_index(top_index), .under_index(under_index),
        .push_wr(push_wr), .scan_end(scan_end), .area_end(area_end), .area(area)
    );

endmodule

`default_nettype wire

// ==== tb_convex_hull_area.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_convex_hull_area;

    localparam int num_points  = 20;
    localparam int num_rows    = 7;
    localparam int clk_period  = 8;
    localparam int watchdog_ns = (num_rows * 130 + 10) * clk_period;

    // one shape per row with its corner at (x0, y0) and legs w and h
    typedef struct packed {
        logic             is_tri;
        hull_pkg::coord_t x0;
        hull_pkg::coord_t y0;
        hull_pkg::coord_t w;
        hull_pkg::coord_t h;
        logic [4:0]       n_edge;
        hull_pkg::area_t  want;
    } row_t;

    // rectangle gives 2wh and right triangle gives wh
    row_t rows [num_rows] = '{
        '{1'b0, 8'd10,  8'd20,  8'd100, 8'd50,  5'd0, 17'd10000},
        '{1'b0, 8'd0,   8'd0,   8'd255, 8'd255, 5'd4, 17'd130050},
        '{1'b0, 8'd40,  8'd30,  8'd7,   8'd9,   5'd8, 17'd126},
        '{1'b1, 8'd5,   8'd5,   8'd120, 8'd80,  5'd0, 17'd9600},
        '{1'b1, 8'd50,  8'd10,  8'd60,  8'd200, 5'd6, 17'd12000},
        '{1'b0, 8'd100, 8'd100, 8'd20,  8'd3,   5'd6, 17'd120},
        '{1'b1, 8'd0,   8'd0,   8'd9,   8'd5,   5'd4, 17'd45}
    };

    logic             clk;
    logic             reset;
    hull_pkg::coord_t x;
    hull_pkg::coord_t y;
    logic             done;
    hull_pkg::area_t  area;

    hull_pkg::point_t pts [$];
    hull_pkg::area_t  held_area;
    integer           seed = 32'ha8468b87;
    int               cur_row;

    convex_hull_area #(.num_points(num_points)) UUT (
        .clk(clk), .reset(reset), .x(x), .y(y), .done(done), .area(area)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic check_area(input hull_pkg::area_t got, input hull_pkg::area_t want,
                              input string what);
        if (got !== want) begin
            $display("** Error at %0t ns: row %0d, %s, area %0d, expected %0d",
                     $time, cur_row, what, got, want);
            $display("Done: errors found");
            $fatal(1, "area check failed");
        end
    endtask

    task automatic check_done(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("** Error at %0t ns: row %0d, %s, done %b, expected %b",
                     $time, cur_row, what, got, want);
            $display("Done: errors found");
            $fatal(1, "done check failed");
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    function automatic int rand_below(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic hull_pkg::point_t make_point(input int px, input int py);
        hull_pkg::point_t p;
        p.x = hull_pkg::coord_t'(px);
        p.y = hull_pkg::coord_t'(py);
        return p;
    endfunction

    task automatic build_points(input row_t r);
        int x0;
        int y0;
        int w;
        int h;
        int dx;
        int lim;
        x0 = r.x0;
        y0 = r.y0;
        w  = r.w;
        h  = r.h;
        pts.delete();
        pts.push_back(make_point(x0, y0));
        pts.push_back(make_point(x0 + w, y0));
        if (!r.is_tri) pts.push_back(make_point(x0 + w, y0 + h));
        pts.push_back(make_point(x0, y0 + h));
        // points on the edges with the bottom ones tying the pivot's y
        for (int i = 0; i < r.n_edge; i++) begin
            case (r.is_tri ? (i % 2) * 3 : i % 4)
                0: pts.push_back(make_point(x0 + 1 + rand_below(w - 1), y0));
                1: pts.push_back(make_point(x0 + w, y0 + 1 + rand_below(h - 1)));
                2: pts.push_back(make_point(x0 + 1 + rand_below(w - 1), y0 + h));
                default: pts.push_back(make_point(x0, y0 + 1 + rand_below(h - 1)));
            endcase
        end
        // interior points strictly inside the shape
        while (pts.size() < num_points) begin
            dx = 1 + rand_below(w - 1);
            if (r.is_tri) begin
                // dx*h + dy*w must stay below w*h
                lim = (h * (w - dx) - 1) / w;
                if (lim < 1) begin
                    dx  = 1;
                    lim = (h * (w - 1) - 1) / w;
                end
            end else begin
                lim = h - 1;
            end
            pts.push_back(make_point(x0 + dx, y0 + 1 + rand_below(lim)));
        end
    endtask

    task automatic shuffle_points();
        hull_pkg::point_t t;
        int               j;
        for (int i = num_points - 1; i > 0; i--) begin
            j      = rand_below(i + 1);
            t      = pts[i];
            pts[i] = pts[j];
            pts[j] = t;
        end
    endtask

    // one point per falling edge that the next rising edge samples
    task automatic load_points();
        for (int k = 0; k < num_points; k++) begin
            x = pts[k].x;
            y = pts[k].y;
            check_done(done, 1'b0, "done raised during load");
            check_area(area, held_area, "area changed during load");
            @(negedge clk);
        end
    endtask

    task automatic wait_result(input hull_pkg::area_t want);
        while (done !== 1'b1) begin
            check_area(area, held_area, "area changed before done");
            @(negedge clk);
        end
        check_area(area, want, "twice hull area");
        held_area = want;
        @(negedge clk);
        check_done(done, 1'b0, "done high for more than one cycle");
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        reset     = 1'b1;
        x         = '0;
        y         = '0;
        held_area = '0;
        cur_row   = 0;
        repeat (5) begin
            @(negedge clk);
            check_done(done, 1'b0, "done raised during reset");
        end
        reset = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            cur_row = r;
            build_points(rows[r]);
            shuffle_points();
            load_points();
            wait_result(rows[r].want);
            $display("row %0d: area %0d", r, area);
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, done never arrived for row %0d",
                 watchdog_ns, cur_row);
        $display("Done: errors found");
        $fatal(1, "simulation hung");
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hull_pkg.sv
hull_sequencer.sv
point_loader.sv
point_store.sv
hull_engine.sv
convex_hull_area.sv
tb_convex_hull_area.sv

// ==== Bender.yml ====
package:
  name: convex_hull_area

sources:
  - files:
      - hull_pkg.sv
      - hull_sequencer.sv
      - point_loader.sv
      - point_store.sv
      - hull_engine.sv
      - convex_hull_area.sv
  - target: test
    files:
      - tb_convex_hull_area.sv
